//--- src/fpu_format_pkg.sv
// Number formats for the double-precision helper unit
// IEEE double fields, integer source formats and operand classes

package fpu_format_pkg;

	localparam int exp_bias  = 1023;
	localparam int exp_width = 11;
	localparam int man_width = 52;

	// One IEEE double word, sign at bit 63
	typedef struct packed
	{
		logic                 sign;
		logic [exp_width-1:0] exponent;
		logic [man_width-1:0] mantissa;
	} fp64_t;

	// Integer source of a conversion
	typedef enum logic [1:0]
	{
		INT_W  = 2'd0,
		INT_WU = 2'd1,
		INT_L  = 2'd2,
		INT_LU = 2'd3
	} int_fmt_e;

	// Operand class flags, set by the decode stage
	typedef struct packed
	{
		logic is_zero;
		logic is_nan;
		logic is_snan;
		logic is_inf;
	} fp_class_t;

endpackage

//--- src/fpu_op_pkg.sv
// Operation codes, mode field and stage records of the helper unit
// The mode field is decoded by operation, as rounding mode or as kind

package fpu_op_pkg;

	import fpu_format_pkg::*;

	typedef enum logic [1:0]
	{
		OP_I2D  = 2'd0,
		OP_CMP  = 2'd1,
		OP_SGNJ = 2'd2
	} fpu_op_e;

	typedef enum logic [2:0]
	{
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3
	} rnd_mode_e;

	typedef enum logic [2:0]
	{
		CMP_LE = 3'd0,
		CMP_LT = 3'd1,
		CMP_EQ = 3'd2
	} cmp_kind_e;

	typedef enum logic [2:0]
	{
		SGNJ_INJECT = 3'd0,
		SGNJ_MOVE   = 3'd3
	} sgnj_kind_e;

	// Rounding mode for OP_I2D, comparison or sign kind for the others
	typedef union packed
	{
		rnd_mode_e  rnd;
		cmp_kind_e  cmp;
		sgnj_kind_e sgnj;
	} op_mode_u;

	typedef struct packed
	{
		logic invalid;
		logic inexact;
	} fp_flags_t;

	////////////////////////////////////////////////////////////////////
	// Records passed from one pipeline stage to the next
	////////////////////////////////////////////////////////////////////

	typedef struct packed
	{
		logic        valid;
		fpu_op_e     op;
		op_mode_u    mode;
		int_fmt_e    int_fmt;
		fp64_t       opa;
		fp64_t       opb;
		fp_class_t   cls_a;
		fp_class_t   cls_b;
		logic [63:0] int_mag;
		logic        int_sign;
	} decode_t;

	// Leading one of mag sits at bit 63, exp is its unbiased position
	typedef struct packed
	{
		logic        sign;
		logic [63:0] mag;
		logic [5:0]  exp;
		logic        zero;
	} norm_t;

	typedef struct packed
	{
		logic [63:0] result;
		fp_flags_t   flags;
	} float_res_t;

	typedef struct packed
	{
		logic     valid;
		fpu_op_e  op;
		op_mode_u mode;
	} stage_ctl_t;

	typedef struct packed
	{
		stage_ctl_t  ctl;
		logic [63:0] result;
		fp_flags_t   flags;
	} round_t;

endpackage

//--- src/fpu_decode.sv
// Stage 1 of the helper unit
// Registers the request, classifies both doubles, takes the integer magnitude

`timescale 1ns/1ps

module fpu_decode
	import fpu_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  fpu_op_e     fpu_op,
	input  op_mode_u    op_mode,
	input  int_fmt_e    int_fmt,
	input  logic [63:0] opa,
	input  logic [63:0] opb,
	output decode_t     dec
);

	logic [63:0] int_mag;
	logic        int_sign;

	function automatic fp_class_t classify(input fp64_t x);
		fp_class_t c;
		logic      exp_max;
		exp_max   = &x.exponent;
		c.is_zero = (x.exponent == '0) && (x.mantissa == '0);
		c.is_inf  = exp_max && (x.mantissa == '0);
		c.is_nan  = exp_max && (x.mantissa != '0);
		// Quiet bit clear marks a signaling NaN
		c.is_snan = c.is_nan && !x.mantissa[man_width-1];
		return c;
	endfunction

	// Absolute value of the integer source, 32-bit formats use opa[31:0] only
	always_comb
	begin
		int_mag  = '0;
		int_sign = 1'b0;
		if (fpu_op == OP_I2D)
		begin
			case (int_fmt)
				INT_W:
				begin
					int_sign = opa[31];
					int_mag  = {32'b0, (opa[31] ? -opa[31:0] : opa[31:0])};
				end
				INT_WU:
					int_mag = {32'b0, opa[31:0]};
				INT_L:
				begin
					int_sign = opa[63];
					int_mag  = opa[63] ? -opa : opa;
				end
				default:
					int_mag = opa;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		dec.op       <= fpu_op;
		dec.mode     <= op_mode;
		dec.int_fmt  <= int_fmt;
		dec.opa      <= opa;
		dec.opb      <= opb;
		dec.cls_a    <= classify(opa);
		dec.cls_b    <= classify(opb);
		dec.int_mag  <= int_mag;
		dec.int_sign <= int_sign;
		if (rst)
			dec.valid <= 1'b0;
		else
			dec.valid <= enable;
	end

endmodule

//--- src/fpu_int_normalise.sv
// Stage 2 conversion path
// Finds the leading one of the integer magnitude and moves it to bit 63

`timescale 1ns/1ps

module fpu_int_normalise
	import fpu_op_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  decode_t dec,
	output norm_t   norm
);

	logic [6:0]  lead_zeros;
	logic [63:0] aligned;

	// Highest set bit wins, an all-zero input counts 64
	always_comb
	begin
		lead_zeros = 7'd64;
		for (int i = 0; i < 64; i++)
		begin
			if (dec.int_mag[i])
				lead_zeros = 7'(63 - i);
		end
	end

	assign aligned = dec.int_mag << lead_zeros;

	always_ff @(posedge clk)
	begin
		norm.mag <= aligned;
		norm.exp <= 6'(7'd63 - lead_zeros);
		if (rst)
		begin
			norm.sign <= 1'b0;
			norm.zero <= 1'b1;
		end
		else
		begin
			norm.sign <= dec.int_sign;
			norm.zero <= (dec.int_mag == '0);
		end
	end

endmodule

//--- src/fpu_compare.sv
// Stage 2 float path
// Ordered compare of two doubles, sign injection and move

`timescale 1ns/1ps

module fpu_compare
	import fpu_op_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  decode_t    dec,
	output float_res_t fres
);

	logic       any_nan;
	logic       any_snan;
	logic       both_zero;
	logic       same;
	logic       less;
	float_res_t fres_d;

	always_comb
	begin
		any_nan   = dec.cls_a.is_nan | dec.cls_b.is_nan;
		any_snan  = dec.cls_a.is_snan | dec.cls_b.is_snan;
		both_zero = dec.cls_a.is_zero & dec.cls_b.is_zero;
		same      = (dec.opa == dec.opb) | both_zero;

		// Sign-magnitude ordering, reversed for two negatives
		if (dec.opa.sign != dec.opb.sign)
			less = dec.opa.sign & ~both_zero;
		else if (dec.opa.sign)
			less = dec.opa[62:0] > dec.opb[62:0];
		else
			less = dec.opa[62:0] < dec.opb[62:0];

		fres_d = '0;
		case (dec.op)
			OP_CMP:
				case (dec.mode.cmp)
					CMP_LE:
					begin
						fres_d.result[0]     = ~any_nan & (less | same);
						fres_d.flags.invalid = any_nan;
					end
					CMP_LT:
					begin
						fres_d.result[0]     = ~any_nan & less;
						fres_d.flags.invalid = any_nan;
					end
					CMP_EQ:
					begin
						// Quiet NaNs only answer false here
						fres_d.result[0]     = ~any_nan & same;
						fres_d.flags.invalid = any_snan;
					end
					default:
						fres_d.flags.invalid = 1'b1;
				endcase
			OP_SGNJ:
				case (dec.mode.sgnj)
					SGNJ_INJECT:
						fres_d.result = {dec.opb.sign, dec.opa[62:0]};
					SGNJ_MOVE:
						fres_d.result = dec.opa;
					default:
						fres_d.flags.invalid = 1'b1;
				endcase
			OP_I2D:
				fres_d = '0;
			default:
				fres_d.flags.invalid = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		fres.result <= fres_d.result;
		if (rst)
			fres.flags <= '0;
		else
			fres.flags <= fres_d.flags;
	end

endmodule

//--- src/fpu_round.sv
// Stage 3 of the helper unit
// Rounds the aligned integer into a double and passes float-path results through

`timescale 1ns/1ps

module fpu_round
	import fpu_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  decode_t    dec,
	input  norm_t      norm,
	input  float_res_t fres,
	output round_t     rnd
);

	stage_ctl_t  ctl_q;
	fp64_t       i2d_word;
	fp_flags_t   i2d_flags;
	logic        guard;
	logic        sticky;
	logic        round_up;
	logic        mode_ok;
	logic [53:0] sig_sum;
	logic        carry;

	//////////////////////////////////////////////////////////////////////
	// Rounding of the 53-bit significand held in mag[63:11]
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		guard   = norm.mag[10];
		sticky  = |norm.mag[9:0];
		mode_ok = 1'b1;
		case (ctl_q.mode.rnd)
			RNE:
				round_up = guard & (sticky | norm.mag[11]);
			RTZ:
				round_up = 1'b0;
			RUP:
				round_up = (guard | sticky) & ~norm.sign;
			RDN:
				round_up = (guard | sticky) & norm.sign;
			default:
			begin
				round_up = 1'b0;
				mode_ok  = 1'b0;
			end
		endcase

		sig_sum = {1'b0, norm.mag[63:11]} + 54'(round_up);
		// A carry out leaves the significand at exactly 2.0 with an all-zero fraction
		carry   = sig_sum[53];

		i2d_word.sign     = norm.sign;
		i2d_word.exponent = 11'(norm.exp) + 11'(exp_bias) + 11'(carry);
		i2d_word.mantissa = sig_sum[51:0];
		i2d_flags.invalid = 1'b0;
		i2d_flags.inexact = guard | sticky;

		if (!mode_ok)
		begin
			i2d_word          = '0;
			i2d_flags.invalid = 1'b1;
			i2d_flags.inexact = 1'b0;
		end
		else if (norm.zero)
		begin
			i2d_word  = '0;
			i2d_flags = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		// Tag follows dec by one stage so it lines up with norm and fres
		ctl_q.op     <= dec.op;
		ctl_q.mode   <= dec.mode;
		rnd.ctl.op   <= ctl_q.op;
		rnd.ctl.mode <= ctl_q.mode;
		if (ctl_q.op == OP_I2D)
		begin
			rnd.result <= i2d_word;
			rnd.flags  <= i2d_flags;
		end
		else
		begin
			rnd.result <= fres.result;
			rnd.flags  <= fres.flags;
		end
		if (rst)
		begin
			ctl_q.valid   <= 1'b0;
			rnd.ctl.valid <= 1'b0;
		end
		else
		begin
			ctl_q.valid   <= dec.valid;
			rnd.ctl.valid <= ctl_q.valid;
		end
	end

endmodule

//--- src/fpu_result.sv
// Stage 4 of the helper unit
// Presents the final word and flags with a one-cycle ready pulse

`timescale 1ns/1ps

module fpu_result
	import fpu_op_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  round_t      rnd,
	output logic [63:0] result,
	output fp_flags_t   flags,
	output logic        ready
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ready  <= 1'b0;
			result <= '0;
			flags  <= '0;
		end
		else
		begin
			ready <= rnd.ctl.valid;
			// Outputs read as zero between results
			if (rnd.ctl.valid)
			begin
				result <= rnd.result;
				flags  <= rnd.flags;
			end
			else
			begin
				result <= '0;
				flags  <= '0;
			end
		end
	end

endmodule

//--- src/fpu_double.sv
// Pipelined double-precision helper unit
// Integer conversion, compare and sign injection in four stages, one issue per cycle

`timescale 1ns/1ps

module fpu_double
	import fpu_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  fpu_op_e     fpu_op,
	input  op_mode_u    op_mode,
	input  int_fmt_e    int_fmt,
	input  logic [63:0] opa,
	input  logic [63:0] opb,
	output logic [63:0] result,
	output fp_flags_t   flags,
	output logic        ready
);

	decode_t    dec;
	norm_t      norm;
	float_res_t fres;
	round_t     rnd;

	fpu_decode i_fpu_decode
	(
		.clk     (clk),
		.rst     (rst),
		.enable  (enable),
		.fpu_op  (fpu_op),
		.op_mode (op_mode),
		.int_fmt (int_fmt),
		.opa     (opa),
		.opb     (opb),
		.dec     (dec)
	);

	// Both stage 2 paths read the same decode record
	fpu_int_normalise i_fpu_int_normalise
	(
		.clk  (clk),
		.rst  (rst),
		.dec  (dec),
		.norm (norm)
	);

	fpu_compare i_fpu_compare
	(
		.clk  (clk),
		.rst  (rst),
		.dec  (dec),
		.fres (fres)
	);

	fpu_round i_fpu_round
	(
		.clk  (clk),
		.rst  (rst),
		.dec  (dec),
		.norm (norm),
		.fres (fres),
		.rnd  (rnd)
	);

	fpu_result i_fpu_result
	(
		.clk    (clk),
		.rst    (rst),
		.rnd    (rnd),
		.result (result),
		.flags  (flags),
		.ready  (ready)
	);

endmodule

//--- include/fpu_ref_model.svh
// Reference model of the helper unit for the testbench
// Conversion, compare and sign operations worked out one value at a time

`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

function automatic void ref_i2d(input logic [63:0] opa, input logic [1:0] fmt,
	input logic [2:0] rnd, output logic [63:0] res, output fpu_op_pkg::fp_flags_t flg);
	logic        neg;
	logic [63:0] mag;
	logic [63:0] kept;
	logic [63:0] rest;
	logic [63:0] half;
	logic        up;
	int          msb;
	int          sh;
	neg = 1'b0;
	res = '0;
	flg = '0;
	case (fmt)
		fpu_format_pkg::INT_W:
		begin
			neg = opa[31];
			mag = {32'b0, (neg ? -opa[31:0] : opa[31:0])};
		end
		fpu_format_pkg::INT_WU:
			mag = {32'b0, opa[31:0]};
		fpu_format_pkg::INT_L:
		begin
			neg = opa[63];
			mag = neg ? -opa : opa;
		end
		default:
			mag = opa;
	endcase
	if (!(rnd inside {fpu_op_pkg::RNE, fpu_op_pkg::RTZ, fpu_op_pkg::RUP, fpu_op_pkg::RDN}))
	begin
		flg.invalid = 1'b1;
		return;
	end
	if (mag == '0)
		return;
	msb = 63;
	while (!mag[msb])
		msb--;
	sh   = (msb > 52) ? msb - 52 : 0;
	kept = mag >> sh;
	rest = mag & ((64'd1 << sh) - 64'd1);
	half = (sh > 0) ? (64'd1 << (sh - 1)) : 64'd0;
	case (rnd)
		fpu_op_pkg::RNE:
			up = (sh > 0) && ((rest > half) || ((rest == half) && kept[0]));
		fpu_op_pkg::RTZ:
			up = 1'b0;
		fpu_op_pkg::RUP:
			up = (rest != '0) && !neg;
		default:
			up = (rest != '0) && neg;
	endcase
	kept = kept + 64'(up);
	if (kept[53])
	begin
		kept = kept >> 1;
		msb++;
	end
	if (msb < 52)
		kept = kept << (52 - msb);
	res = {neg, 11'(msb + 1023), kept[51:0]};
	flg.inexact = (rest != '0);
endfunction

function automatic void ref_cmp(input logic [63:0] a, input logic [63:0] b,
	input logic [2:0] kind, output logic [63:0] res, output fpu_op_pkg::fp_flags_t flg);
	logic nan;
	logic snan;
	logic eq;
	logic lt;
	nan  = ((&a[62:52]) && (|a[51:0])) || ((&b[62:52]) && (|b[51:0]));
	snan = ((&a[62:52]) && (|a[50:0]) && !a[51]) || ((&b[62:52]) && (|b[50:0]) && !b[51]);
	eq   = (a == b) || ((a[62:0] == '0) && (b[62:0] == '0));
	if (a[63] != b[63])
		lt = a[63] && !eq;
	else
		lt = a[63] ? (a[62:0] > b[62:0]) : (a[62:0] < b[62:0]);
	res = '0;
	flg = '0;
	case (kind)
		fpu_op_pkg::CMP_LE:
		begin
			res[0]      = !nan && (lt || eq);
			flg.invalid = nan;
		end
		fpu_op_pkg::CMP_LT:
		begin
			res[0]      = !nan && lt;
			flg.invalid = nan;
		end
		fpu_op_pkg::CMP_EQ:
		begin
			res[0]      = !nan && eq;
			flg.invalid = snan;
		end
		default:
			flg.invalid = 1'b1;
	endcase
endfunction

function automatic void ref_sgnj(input logic [63:0] a, input logic [63:0] b,
	input logic [2:0] kind, output logic [63:0] res, output fpu_op_pkg::fp_flags_t flg);
	res = '0;
	flg = '0;
	if (kind == fpu_op_pkg::SGNJ_INJECT)
		res = {b[63], a[62:0]};
	else if (kind == fpu_op_pkg::SGNJ_MOVE)
		res = a;
	else
		flg.invalid = 1'b1;
endfunction

`endif

//--- testbench/tb_fpu_double.sv
// Testbench for the double-precision helper unit
// Random requests are checked against a reference model on every ready pulse

`timescale 1ns/1ps

module tb_fpu_double
	import fpu_format_pkg::*;
	import fpu_op_pkg::*;
();

	`include "fpu_ref_model.svh"

	localparam int reset_cycles  = 16;
	localparam int quiet_cycles  = 8;
	localparam int drain_cycles  = 8;
	localparam int n_tests       = 5;
	localparam int n_i2d         = 400;
	localparam int n_cmp         = 300;
	localparam int n_sgnj        = 100;
	localparam int n_unused      = 15;
	localparam int n_mix         = 200;
	localparam int total_req     = n_i2d + n_cmp + n_sgnj + n_unused + n_mix;
	localparam int timeout_cycles = total_req + reset_cycles + quiet_cycles
		+ n_tests * drain_cycles + 40;

	logic        clk;
	logic        rst;
	logic        enable;
	fpu_op_e     fpu_op;
	op_mode_u    op_mode;
	int_fmt_e    int_fmt;
	logic [63:0] opa;
	logic [63:0] opb;
	logic [63:0] result;
	fp_flags_t   flags;
	logic        ready;

	// Expected results in issue order together with the edge that sampled each request
	logic [63:0] exp_res_q[$];
	fp_flags_t   exp_flg_q[$];
	int          exp_edge_q[$];

	int cycle       = 0;
	int req_count   = 0;
	int pop_count   = 0;
	int pass_count  = 0;
	int error_count = 0;

	fpu_double i_fpu_double
	(
		.clk     (clk),
		.rst     (rst),
		.enable  (enable),
		.fpu_op  (fpu_op),
		.op_mode (op_mode),
		.int_fmt (int_fmt),
		.opa     (opa),
		.opb     (opb),
		.result  (result),
		.flags   (flags),
		.ready   (ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic check_result(input logic [63:0] got, input logic [63:0] want,
		input string what);
		if (got !== want)
		begin
			$display("error at %0t: %s result %h, expected %h", $time, what, got, want);
			error_count++;
		end
		else
			pass_count++;
	endtask

	task automatic check_flags(input fp_flags_t got, input fp_flags_t want, input string what);
		if (got !== want)
		begin
			$display("error at %0t: %s flags %b, expected %b", $time, what, got, want);
			error_count++;
		end
		else
			pass_count++;
	endtask

	// Mixes signed zeros, infinities, both NaN kinds and values near one
	function automatic logic [63:0] random_double();
		logic        sign;
		logic [63:0] word;
		sign = 1'($urandom);
		case ($urandom % 8)
			0:
				word = {sign, 63'b0};
			1:
				word = {sign, 11'h7ff, 52'b0};
			2:
				word = {sign, 11'h7ff, 1'b1, 51'($urandom)};
			3:
				word = {sign, 11'h7ff, 1'b0, 51'($urandom) | 51'd1};
			4:
				word = {sign, 11'h3ff, 52'({$urandom, $urandom})};
			default:
				word = {$urandom, $urandom};
		endcase
		return word;
	endfunction

	task automatic issue(input fpu_op_e op, input logic [2:0] mode, input int_fmt_e fmt,
		input logic [63:0] a, input logic [63:0] b);
		logic [63:0] want_res;
		fp_flags_t   want_flg;
		case (op)
			OP_I2D:
				ref_i2d(a, fmt, mode, want_res, want_flg);
			OP_CMP:
				ref_cmp(a, b, mode, want_res, want_flg);
			default:
				ref_sgnj(a, b, mode, want_res, want_flg);
		endcase
		@(posedge clk);
		#5;
		enable  = 1'b1;
		fpu_op  = op;
		op_mode = op_mode_u'(mode);
		int_fmt = fmt;
		opa     = a;
		opb     = b;
		exp_res_q.push_back(want_res);
		exp_flg_q.push_back(want_flg);
		// Sampled at the next rising edge
		exp_edge_q.push_back(cycle + 1);
		req_count++;
	endtask

	task automatic issue_random_i2d();
		logic [63:0] a;
		a = {$urandom, $urandom} >> ($urandom % 64);
		issue(OP_I2D, 3'($urandom % 4), int_fmt_e'(2'($urandom)), a, 64'b0);
	endtask

	task automatic issue_random_cmp();
		logic [63:0] a;
		logic [63:0] b;
		a = random_double();
		case ($urandom % 4)
			0:
				b = a;
			1:
				b = {~a[63], a[62:0]};
			default:
				b = random_double();
		endcase
		issue(OP_CMP, 3'($urandom % 3), INT_W, a, b);
	endtask

	task automatic issue_random_sgnj();
		logic [2:0] kind;
		kind = ($urandom % 2) ? 3'(SGNJ_MOVE) : 3'(SGNJ_INJECT);
		issue(OP_SGNJ, kind, INT_W, random_double(), random_double());
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#5;
		enable = 1'b0;
	endtask

	task automatic end_test(input int num, input string name, input int errs_before,
		input int reqs_before);
		int waited;
		idle_cycle();
		waited = 0;
		while (exp_res_q.size() != 0 && waited < drain_cycles)
		begin
			@(posedge clk);
			waited++;
		end
		$display("test %0d %s: %0d requests, %0d errors", num, name,
			req_count - reqs_before, error_count - errs_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result monitor that samples the outputs at the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		logic [63:0] want_res;
		fp_flags_t   want_flg;
		int          want_edge;
		if (!rst && ready)
		begin
			if (exp_res_q.size() == 0)
			begin
				$display("ready went high at %0t with no request waiting for a result", $time);
				error_count++;
			end
			else
			begin
				want_res  = exp_res_q.pop_front();
				want_flg  = exp_flg_q.pop_front();
				want_edge = exp_edge_q.pop_front();
				check_result(result, want_res, $sformatf("request %0d", pop_count));
				check_flags(flags, want_flg, $sformatf("request %0d", pop_count));
				// Ready must follow the sampling edge by exactly three edges
				if (cycle != want_edge + 3)
				begin
					$display("error at %0t: request %0d ready after edge %0d, expected edge %0d",
						$time, pop_count, cycle, want_edge + 3);
					error_count++;
				end
				pop_count++;
			end
		end
	end

	initial
	begin
		#(timeout_cycles * 100);
		$display("watchdog: the run did not finish within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int errs;
		int reqs;
		void'($urandom(47));
		rst     = 1'b1;
		enable  = 1'b0;
		fpu_op  = OP_I2D;
		op_mode = op_mode_u'(3'b0);
		int_fmt = INT_W;
		opa     = '0;
		opb     = '0;
		repeat (reset_cycles)
			@(posedge clk);
		#5;
		rst = 1'b0;

		// Test 1 checks that the outputs stay quiet while enable is low
		errs = error_count;
		reqs = req_count;
		repeat (quiet_cycles)
		begin
			@(negedge clk);
			check_result(result, 64'b0, "idle");
			check_flags(flags, 2'b0, "idle");
		end
		end_test(1, "idle after reset", errs, reqs);

		// Test 2 walks the edge values first and then sends random requests
		errs = error_count;
		reqs = req_count;
		for (int i = 0; i < n_i2d; i++)
		begin
			logic [63:0] a;
			if (i < 128)
			begin
				case (i % 8)
					0:
						a = 64'h0;
					1:
						a = 64'h0000_0000_8000_0000;
					2:
						a = 64'h8000_0000_0000_0000;
					3:
						a = '1;
					4:
						a = {1'b1, 52'({$urandom, $urandom}), 1'b1, 10'b0};
					5:
						a = {1'b1, 52'({$urandom, $urandom}), 1'b1, 10'b0} >> 3;
					6:
						a = 64'h0020_0000_0000_0001;
					default:
						a = {$urandom, $urandom};
				endcase
				issue(OP_I2D, 3'((i / 8) % 4), int_fmt_e'(2'((i / 32) % 4)), a, 64'b0);
			end
			else
				issue_random_i2d();
		end
		end_test(2, "integer to double", errs, reqs);

		errs = error_count;
		reqs = req_count;
		for (int i = 0; i < n_cmp; i++)
			issue_random_cmp();
		end_test(3, "compare", errs, reqs);

		// Test 4 also sends every unused mode code once
		errs = error_count;
		reqs = req_count;
		for (int i = 0; i < n_sgnj; i++)
			issue_random_sgnj();
		for (int m = 4; m < 8; m++)
			issue(OP_I2D, 3'(m), INT_L, {$urandom, $urandom}, 64'b0);
		for (int m = 3; m < 8; m++)
			issue(OP_CMP, 3'(m), INT_W, random_double(), random_double());
		for (int m = 0; m < 8; m++)
		begin
			if (m != 0 && m != 3)
				issue(OP_SGNJ, 3'(m), INT_W, random_double(), random_double());
		end
		end_test(4, "sign injection and unused modes", errs, reqs);

		errs = error_count;
		reqs = req_count;
		for (int i = 0; i < n_mix; i++)
		begin
			case ($urandom % 3)
				0:
					issue_random_i2d();
				1:
					issue_random_cmp();
				default:
					issue_random_sgnj();
			endcase
		end
		end_test(5, "back-to-back mixed", errs, reqs);

		if (exp_res_q.size() != 0)
		begin
			$display("%0d expected results were never answered", exp_res_q.size());
			error_count++;
		end
		$display("checks passed: %0d, checks failed: %0d", pass_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
src/fpu_format_pkg.sv
src/fpu_op_pkg.sv
src/fpu_decode.sv
src/fpu_int_normalise.sv
src/fpu_compare.sv
src/fpu_round.sv
src/fpu_result.sv
src/fpu_double.sv
testbench/tb_fpu_double.sv

//--- Makefile
TOP = tb_fpu_double

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
